// ==== hw/chip_top.sv ====
`timescale 1ns/1ps

module chip_top (
  input  logic                                  clk,
  input  logic                                  rst_i,
  output logic [tag_pkg::trace_addr_width-1:0]  rom_addr_o,
  input  logic [tag_pkg::trace_word_width-1:0]  rom_data_i,
  output logic                                  tag_done_o,
  output logic [tag_pkg::tag_payload_width-1:0] cfg1_o,
  output logic [tag_pkg::tag_payload_width-1:0] cfg2_o,
  output logic [tag_pkg::tag_payload_width-1:0] cfg3_o,
  input  logic                                  up_v_i,
  input  logic [link_pkg::link_data_width-1:0]  up_data_i,
  output logic                                  up_ready_o,
  output logic                                  link_v_o,
  output logic [link_pkg::link_data_width-1:0]  link_data_o,
  input  logic                                  link_token_i,
  input  logic                                  link_v_i,
  input  logic [link_pkg::link_data_width-1:0]  link_data_i,
  output logic                                  link_token_o,
  output logic                                  down_v_o,
  output logic [link_pkg::link_data_width-1:0]  down_data_o,
  input  logic                                  down_ready_i
);

  logic                                  tag_v;
  logic                                  tag_bit;
  logic [tag_pkg::tag_num_clients-1:0]   tag_wr;
  logic                                  tag_clr;
  logic [tag_pkg::tag_payload_width-1:0] tag_value;
  logic [tag_pkg::tag_payload_width-1:0] cfg [tag_pkg::tag_num_clients];

  //////////////////////////////////////////////////
  // Configuration path
  //////////////////////////////////////////////////

  tag_trace_replay replay (
    .clk        (clk),
    .rst_i      (rst_i),
    .rom_addr_o (rom_addr_o),
    .rom_data_i (rom_data_i),
    .tag_v_o    (tag_v),
    .tag_bit_o  (tag_bit),
    .done_o     (tag_done_o)
  );

  tag_master master (
    .clk       (clk),
    .rst_i     (rst_i),
    .tag_v_i   (tag_v),
    .tag_bit_i (tag_bit),
    .wr_o      (tag_wr),
    .clr_o     (tag_clr),
    .value_o   (tag_value)
  );

  // All clients share the value bus and each sees its own write strobe
  for (genvar i = 0; i < tag_pkg::tag_num_clients; i++)
  begin : g_client
    tag_client client (
      .clk     (clk),
      .rst_i   (rst_i),
      .wr_i    (tag_wr[i]),
      .clr_i   (tag_clr),
      .value_i (tag_value),
      .cfg_o   (cfg[i])
    );
  end

  // Clients 1 to 3 leave the chip as settings
  assign cfg1_o = cfg[1];
  assign cfg2_o = cfg[2];
  assign cfg3_o = cfg[3];

  //////////////////////////////////////////////////
  // Link path
  //////////////////////////////////////////////////

  // Client 0 bit 0 opens the transmitter
  link_tx tx (
    .clk          (clk),
    .rst_i        (rst_i),
    .enable_i     (cfg[0][0]),
    .up_v_i       (up_v_i),
    .up_data_i    (up_data_i),
    .up_ready_o   (up_ready_o),
    .link_v_o     (link_v_o),
    .link_data_o  (link_data_o),
    .link_token_i (link_token_i)
  );

  link_rx rx (
    .clk          (clk),
    .rst_i        (rst_i),
    .link_v_i     (link_v_i),
    .link_data_i  (link_data_i),
    .link_token_o (link_token_o),
    .down_v_o     (down_v_o),
    .down_data_o  (down_data_o),
    .down_ready_i (down_ready_i)
  );

endmodule

// ==== hw/link_pkg.sv ====
package link_pkg;

  //////////////////////////////////////////////////
  // Credit-based link sizing
  //////////////////////////////////////////////////

  // Width of one word on the link and on both core ports
  localparam int link_data_width   = 16;

  // Tokens held by the transmitter after reset, and also the receiver FIFO depth
  localparam int link_credits      = 4;

  // Holds 0 to link_credits inclusive
  localparam int link_credit_width = 3;

  // FIFO pointers wrap on their own because the depth is a power of two
  localparam int link_ptr_width    = $clog2(link_credits);

endpackage

// ==== hw/link_rx.sv ====
`timescale 1ns/1ps

module link_rx (
  input  logic                                 clk,
  input  logic                                 rst_i,
  input  logic                                 link_v_i,
  input  logic [link_pkg::link_data_width-1:0] link_data_i,
  output logic                                 link_token_o,
  output logic                                 down_v_o,
  output logic [link_pkg::link_data_width-1:0] down_data_o,
  input  logic                                 down_ready_i
);

  logic [link_pkg::link_data_width-1:0]   mem [link_pkg::link_credits];
  logic [link_pkg::link_ptr_width-1:0]    wr_ptr_r;
  logic [link_pkg::link_ptr_width-1:0]    rd_ptr_r;
  logic [link_pkg::link_credit_width-1:0] count_r;
  logic                                   fifo_full;
  logic                                   push;
  logic                                   pop;
  logic                                   token_r;

  assign fifo_full   = (count_r == link_pkg::link_credit_width'(link_pkg::link_credits));
  assign push        = link_v_i && !fifo_full;
  assign down_v_o    = (count_r != '0);
  assign down_data_o = mem[rd_ptr_r];
  assign pop         = down_v_o && down_ready_i;

  //////////////////////////////////////////////////
  // Circular FIFO
  //////////////////////////////////////////////////

  // Storage is written on arrival and read from the head
  always_ff @(posedge clk)
  begin
    if (push)
    begin
      mem[wr_ptr_r] <= link_data_i;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst_i)
    begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
      token_r  <= 1'b0;
    end
    else
    begin
      if (push)
      begin
        wr_ptr_r <= wr_ptr_r + 1'b1;
      end
      if (pop)
      begin
        rd_ptr_r <= rd_ptr_r + 1'b1;
      end
      // Occupancy moves only when push and pop differ
      case ({push, pop})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase
      // Every popped word frees a slot, so one token goes back
      token_r <= pop;
    end
  end

  assign link_token_o = token_r;

endmodule

// ==== hw/link_tx.sv ====
`timescale 1ns/1ps

module link_tx (
  input  logic                                 clk,
  input  logic                                 rst_i,
  input  logic                                 enable_i,
  input  logic                                 up_v_i,
  input  logic [link_pkg::link_data_width-1:0] up_data_i,
  output logic                                 up_ready_o,
  output logic                                 link_v_o,
  output logic [link_pkg::link_data_width-1:0] link_data_o,
  input  logic                                 link_token_i
);

  logic [link_pkg::link_credit_width-1:0] credit_r;
  logic [link_pkg::link_data_width-1:0]   data_r;
  logic                                   v_r;
  logic                                   accept;

  // Each credit stands for one free slot in the far FIFO
  assign up_ready_o = enable_i && (credit_r != '0);
  assign accept     = up_v_i && up_ready_o;

  //////////////////////////////////////////////////
  // Credit counter and output stage
  //////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (rst_i)
    begin
      credit_r <= link_pkg::link_credit_width'(link_pkg::link_credits);
      v_r      <= 1'b0;
    end
    else
    begin
      v_r <= accept;
      // A word out and a token back in the same cycle cancel
      case ({accept, link_token_i})
        2'b10:   credit_r <= credit_r - 1'b1;
        2'b01:   credit_r <= credit_r + 1'b1;
        default: credit_r <= credit_r;
      endcase
    end
  end

  // Accepted word goes onto the link in the next cycle
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      data_r <= up_data_i;
    end
  end

  assign link_v_o    = v_r;
  assign link_data_o = data_r;

endmodule

// ==== hw/tag_client.sv ====
`timescale 1ns/1ps

module tag_client (
  input  logic                                  clk,
  input  logic                                  rst_i,
  input  logic                                  wr_i,
  input  logic                                  clr_i,
  input  logic [tag_pkg::tag_payload_width-1:0] value_i,
  output logic [tag_pkg::tag_payload_width-1:0] cfg_o
);

  logic [tag_pkg::tag_payload_width-1:0] cfg_r;

  //////////////////////////////////////////////////
  // Configuration register
  //////////////////////////////////////////////////

  // Only the write addressed to this client gets through
  always_ff @(posedge clk)
  begin
    if (rst_i)
    begin
      cfg_r <= '0;
    end
    else if (wr_i)
    begin
      // A packet with data_not_reset low clears the register
      if (clr_i)
      begin
        cfg_r <= '0;
      end
      else
      begin
        cfg_r <= value_i;
      end
    end
  end

  assign cfg_o = cfg_r;

endmodule

// ==== hw/tag_master.sv ====
`timescale 1ns/1ps

module tag_master (
  input  logic                                  clk,
  input  logic                                  rst_i,
  input  logic                                  tag_v_i,
  input  logic                                  tag_bit_i,
  output logic [tag_pkg::tag_num_clients-1:0]   wr_o,
  output logic                                  clr_o,
  output logic [tag_pkg::tag_payload_width-1:0] value_o
);

  logic [tag_pkg::tag_bit_idx_width-1:0] idx_r;
  logic [tag_pkg::tag_header_bits-1:0]   hdr_r;
  logic [tag_pkg::tag_payload_width-1:0] pl_r;
  logic [tag_pkg::tag_payload_width-1:0] pl_cur;
  logic [tag_pkg::tag_len_width-1:0]     len_cur;
  logic [tag_pkg::tag_len_width-1:0]     pl_idx;
  logic [tag_pkg::tag_bit_idx_width-1:0] end_idx;
  logic [tag_pkg::tag_id_width-1:0]      id_cur;
  logic                                  in_payload;
  logic                                  last_bit;

  // Header layout is start at bit 0, id at 2:1, data_not_reset at 3, length at 6:4
  assign id_cur     = hdr_r[2:1];
  assign in_payload = (idx_r >= tag_pkg::tag_header_bits);

  // On the last header bit the top length bit is still on the wire
  assign len_cur = (idx_r == tag_pkg::tag_header_bits - 1) ? {tag_bit_i, hdr_r[5:4]}
                                                           : hdr_r[6:4];

  assign end_idx = tag_pkg::tag_bit_idx_width'(tag_pkg::tag_header_bits - 1)
                 + tag_pkg::tag_bit_idx_width'(len_cur);

  assign pl_idx = tag_pkg::tag_len_width'(idx_r - tag_pkg::tag_header_bits);

  // Payload with the bit that is arriving now merged in
  always_comb
  begin
    pl_cur = pl_r;
    if (in_payload)
    begin
      pl_cur[pl_idx] = tag_bit_i;
    end
  end

  // The packet ends once the length says no more payload follows
  assign last_bit = tag_v_i && (idx_r >= tag_pkg::tag_header_bits - 1) && (idx_r == end_idx);

  //////////////////////////////////////////////////
  // Client write, taken by the client on this edge
  //////////////////////////////////////////////////

  assign wr_o    = last_bit ? (tag_pkg::tag_num_clients'(1) << id_cur) : '0;
  assign clr_o   = ~hdr_r[3];
  assign value_o = pl_cur;

  // Bit counter only leaves zero on a valid start bit
  always_ff @(posedge clk)
  begin
    if (rst_i)
    begin
      idx_r <= '0;
    end
    else if (!tag_v_i || last_bit || (idx_r == '0 && !tag_bit_i))
    begin
      idx_r <= '0;
    end
    else
    begin
      idx_r <= idx_r + 1'b1;
    end
  end

  // Header and payload fields fill as the bits arrive
  always_ff @(posedge clk)
  begin
    if (tag_v_i && !in_payload)
    begin
      hdr_r[idx_r[2:0]] <= tag_bit_i;
    end
    // Short payloads end up zero-extended
    if (tag_v_i && idx_r == '0)
    begin
      pl_r <= '0;
    end
    else if (tag_v_i && in_payload)
    begin
      pl_r <= pl_cur;
    end
  end

endmodule

// ==== hw/tag_pkg.sv ====
package tag_pkg;

  //////////////////////////////////////////////////
  // Tag bus geometry
  //////////////////////////////////////////////////

  // Four configuration clients sit behind the tag master
  localparam int tag_num_clients   = 4;
  localparam int tag_id_width      = 2;
  localparam int tag_payload_width = 7;
  localparam int tag_len_width     = 3;

  // Start bit, id, data_not_reset and length make up the packet header
  localparam int tag_header_bits   = 7;
  localparam int tag_packet_bits   = tag_header_bits + tag_payload_width;

  // Wide enough to count every bit of the longest packet
  localparam int tag_bit_idx_width = 4;

  //////////////////////////////////////////////////
  // Trace ROM format
  //////////////////////////////////////////////////

  localparam int trace_addr_width  = 6;
  localparam int trace_word_width  = 16;
  localparam int trace_count_width = 14;

  // Replay FSM state codes
  localparam logic [1:0] replay_fetch = 2'd0;
  localparam logic [1:0] replay_shift = 2'd1;
  localparam logic [1:0] replay_wait  = 2'd2;
  localparam logic [1:0] replay_done  = 2'd3;

  // Opcode zero is left unused, so a blank ROM word ends the trace
  typedef enum logic [1:0] {
    op_send   = 2'd1,
    op_wait   = 2'd2,
    op_finish = 2'd3
  } trace_op_e;

  // A send command carries one complete tag packet
  typedef struct packed {
    trace_op_e                    op;
    logic [tag_id_width-1:0]      id;
    logic                         data_not_reset;
    logic [tag_len_width-1:0]     len;
    logic [tag_payload_width-1:0] payload;
    logic                         spare;
  } trace_send_s;

  // A wait command idles the bus for a number of cycles
  typedef struct packed {
    trace_op_e                    op;
    logic [trace_count_width-1:0] count;
  } trace_wait_s;

  // The opcode sits in the same place in both views
  typedef union packed {
    trace_send_s send_view;
    trace_wait_s wait_view;
  } trace_word_u;

endpackage

// ==== hw/tag_trace_replay.sv ====
`timescale 1ns/1ps

module tag_trace_replay (
  input  logic                                 clk,
  input  logic                                 rst_i,
  output logic [tag_pkg::trace_addr_width-1:0] rom_addr_o,
  input  logic [tag_pkg::trace_word_width-1:0] rom_data_i,
  output logic                                 tag_v_o,
  output logic                                 tag_bit_o,
  output logic                                 done_o
);

  tag_pkg::trace_word_u                         word;
  logic [1:0]                                   state_r;
  logic [tag_pkg::trace_addr_width-1:0]         addr_r;
  logic [tag_pkg::trace_count_width-1:0]        cnt_r;
  logic [tag_pkg::tag_bit_idx_width-1:0]        bits_left_r;
  logic [tag_pkg::tag_bit_idx_width-1:0]        send_bits;
  logic [tag_pkg::tag_packet_bits-1:0]          shift_r;

  // The ROM answers in the same cycle, so the word is decoded straight away
  assign word = rom_data_i;

  // Header bits plus the payload bits that the length asks for
  assign send_bits = tag_pkg::tag_bit_idx_width'(tag_pkg::tag_header_bits)
                   + tag_pkg::tag_bit_idx_width'(word.send_view.len);

  assign rom_addr_o = addr_r;
  assign tag_v_o    = (state_r == tag_pkg::replay_shift);
  assign tag_bit_o  = shift_r[0];
  assign done_o     = (state_r == tag_pkg::replay_done);

  //////////////////////////////////////////////////
  // Command FSM
  //////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (rst_i)
    begin
      state_r     <= tag_pkg::replay_fetch;
      addr_r      <= '0;
      cnt_r       <= '0;
      bits_left_r <= '0;
    end
    else
    begin
      case (state_r)
        tag_pkg::replay_fetch:
        begin
          case (word.send_view.op)
            tag_pkg::op_send:
            begin
              addr_r      <= addr_r + 1'b1;
              bits_left_r <= send_bits;
              state_r     <= tag_pkg::replay_shift;
            end
            tag_pkg::op_wait:
            begin
              addr_r <= addr_r + 1'b1;
              cnt_r  <= word.wait_view.count;
              // A zero count falls through to the next word
              if (word.wait_view.count != '0)
              begin
                state_r <= tag_pkg::replay_wait;
              end
            end
            // Finish, or an unknown opcode, stops the trace here
            default:
            begin
              state_r <= tag_pkg::replay_done;
            end
          endcase
        end
        tag_pkg::replay_shift:
        begin
          bits_left_r <= bits_left_r - 1'b1;
          if (bits_left_r == 1)
          begin
            state_r <= tag_pkg::replay_fetch;
          end
        end
        tag_pkg::replay_wait:
        begin
          cnt_r <= cnt_r - 1'b1;
          if (cnt_r == 1)
          begin
            state_r <= tag_pkg::replay_fetch;
          end
        end
        // Done is sticky until the next reset
        default:
        begin
          state_r <= tag_pkg::replay_done;
        end
      endcase
    end
  end

  // Packet image leaves LSB first, start bit at the bottom
  always_ff @(posedge clk)
  begin
    if (state_r == tag_pkg::replay_fetch)
    begin
      shift_r <= {word.send_view.payload, word.send_view.len,
                  word.send_view.data_not_reset, word.send_view.id, 1'b1};
    end
    else if (state_r == tag_pkg::replay_shift)
    begin
      shift_r <= shift_r >> 1;
    end
  end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module tb_top -o tb_sim

# A failed assertion stops the simulator, so its status is judged by the search below
output=$(./obj_dir/tb_sim 2>&1) || true
echo "$output"

if echo "$output" | grep -qF '*** PASSED ***'; then
  exit 0
fi
exit 1

// ==== tests/link_credit_assert.sv ====
`timescale 1ns/1ps

// One checker serves both link ends
// On link_tx the level is the credit count and a token must never arrive with all credits home
// On link_rx the level is the FIFO occupancy and a word must never arrive into a full FIFO
module link_credit_assert (
  input logic                                   clk,
  input logic                                   rst_i,
  input logic [link_pkg::link_credit_width-1:0] level_i,
  input logic                                   arrive_i
);

  //////////////////////////////////////////////////
  // Credit and FIFO limits
  //////////////////////////////////////////////////

  level_limit: assert property (@(posedge clk) disable iff (rst_i)
    level_i <= link_pkg::link_credit_width'(link_pkg::link_credits))
    else $error("link level above the credit limit");

  // Nothing may land on a side that is already at its limit
  no_overflow: assert property (@(posedge clk) disable iff (rst_i)
    arrive_i |-> level_i < link_pkg::link_credit_width'(link_pkg::link_credits))
    else $error("link arrival while the level is at its limit");

endmodule

bind link_tx link_credit_assert tx_limits (
  .clk      (clk),
  .rst_i    (rst_i),
  .level_i  (credit_r),
  .arrive_i (link_token_i)
);

bind link_rx link_credit_assert rx_limits (
  .clk      (clk),
  .rst_i    (rst_i),
  .level_i  (count_r),
  .arrive_i (link_v_i)
);

// ==== tests/tb_checker.sv ====
`timescale 1ns/1ps

module tb_checker (
  input  logic                                  clk,
  input  logic                                  rst_i,
  input  logic [tag_pkg::trace_word_width-1:0]  rom_i [2**tag_pkg::trace_addr_width],
  input  logic [tag_pkg::trace_addr_width-1:0]  rom_addr_i,
  input  int                                    words_i,
  input  logic                                  up_v_i,
  input  logic [link_pkg::link_data_width-1:0]  up_data_i,
  input  logic                                  up_ready_i,
  input  logic                                  link_v_i,
  input  logic                                  link_token_i,
  input  logic                                  tag_done_i,
  input  logic [tag_pkg::tag_payload_width-1:0] cfg1_i,
  input  logic [tag_pkg::tag_payload_width-1:0] cfg2_i,
  input  logic [tag_pkg::tag_payload_width-1:0] cfg3_i,
  input  logic                                  down_v_i,
  input  logic [link_pkg::link_data_width-1:0]  down_data_i,
  input  logic                                  down_ready_i,
  input  logic                                  end_i,
  output int                                    errors_o,
  output int                                    delivered_o,
  output logic                                  finished_o
);

  logic [tag_pkg::tag_payload_width-1:0] model [tag_pkg::tag_num_clients];
  logic [link_pkg::link_data_width-1:0]  expect_q [$];
  logic [link_pkg::link_data_width-1:0]  oldest;
  int   cycle             = 0;
  int   rst_edges         = 0;
  int   first_write_cycle = 0;
  int   enable_cycle      = -1;
  int   done_cycle        = 0;
  int   finish_addr       = -1;
  int   errors            = 0;
  int   delivered         = 0;
  logic walked            = 1'b0;
  logic done_seen         = 1'b0;
  logic finished          = 1'b0;

  assign errors_o    = errors;
  assign delivered_o = delivered;
  assign finished_o  = finished;

  task automatic report_mismatch(input string what);
    errors++;
    $display("ERR %0t: %s", $time, what);
  endtask

  //////////////////////////////////////////////////
  // Trace model
  //////////////////////////////////////////////////

  // Cycle n is the n-th rising edge after reset is released
  // A command fetched at cycle t lands its write at t + 7 + len and the next fetch is one later
  function automatic void walk_trace();
    tag_pkg::trace_word_u                  w;
    logic [tag_pkg::tag_payload_width-1:0] mask;
    int                                    t;
    int                                    len;
    t = 1;
    foreach (model[i])
    begin
      model[i] = '0;
    end
    for (int a = 0; a < 2**tag_pkg::trace_addr_width; a++)
    begin
      w = rom_i[a];
      if (w.send_view.op == tag_pkg::op_send)
      begin
        len  = int'(w.send_view.len);
        mask = tag_pkg::tag_payload_width'((1 << len) - 1);
        if (w.send_view.data_not_reset)
        begin
          model[w.send_view.id] = w.send_view.payload & mask;
        end
        else
        begin
          model[w.send_view.id] = '0;
        end
        if (first_write_cycle == 0)
        begin
          first_write_cycle = t + 7 + len;
        end
        // The link opens with the first write that leaves client 0 bit 0 set
        if (w.send_view.id == 0 && model[0][0] && enable_cycle < 0)
        begin
          enable_cycle = t + 7 + len;
        end
        t = t + 8 + len;
      end
      else if (w.send_view.op == tag_pkg::op_wait)
      begin
        t = t + 1 + int'(w.wait_view.count);
      end
      else
      begin
        // Finish ends the trace, done shows right after this fetch
        done_cycle  = t;
        finish_addr = a;
        break;
      end
    end
  endfunction

  task automatic compare_cfg(input int idx, input logic [tag_pkg::tag_payload_width-1:0] got);
    if (got !== model[idx])
    begin
      report_mismatch($sformatf("cfg%0d_o is %h, expected %h", idx, got, model[idx]));
    end
  endtask

  always @(posedge clk)
  begin
    if (rst_i)
    begin
      cycle     <= 0;
      rst_edges <= rst_edges + 1;
    end
    else
    begin
      cycle <= cycle + 1;
    end
  end

  //////////////////////////////////////////////////
  // Checks, sampled mid-cycle where all signals are settled
  //////////////////////////////////////////////////

  always @(negedge clk)
  begin
    if (!walked)
    begin
      walk_trace();
      walked = 1'b1;
    end

    // Everything stays quiet in reset and until the first tag write takes effect
    if ((rst_i && rst_edges > 0) || (!rst_i && cycle < first_write_cycle))
    begin
      if ((up_ready_i | down_v_i | link_v_i | link_token_i | tag_done_i) !== 1'b0)
      begin
        report_mismatch("link or done output high before the first tag write");
      end
      if (cfg1_i !== '0 || cfg2_i !== '0 || cfg3_i !== '0)
      begin
        report_mismatch("config outputs not zero before the first tag write");
      end
    end

    if (!rst_i)
    begin
      // The transmitter must wait for client 0 and then open with full credit
      if (cycle < enable_cycle && up_ready_i)
      begin
        report_mismatch("up_ready_o high before client 0 enabled the link");
      end
      if (cycle == enable_cycle && !up_ready_i)
      begin
        report_mismatch("up_ready_o still low once client 0 enabled the link");
      end

      if (tag_done_i && !done_seen)
      begin
        done_seen = 1'b1;
        if (cycle != done_cycle)
        begin
          report_mismatch($sformatf("tag_done_o rose in cycle %0d, expected %0d",
                                    cycle, done_cycle));
        end
        // The replay stops on the finish word without stepping past it
        if (int'(rom_addr_i) != finish_addr)
        begin
          report_mismatch($sformatf("rom_addr_o is %0d at done, expected %0d",
                                    rom_addr_i, finish_addr));
        end
        compare_cfg(1, cfg1_i);
        compare_cfg(2, cfg2_i);
        compare_cfg(3, cfg3_i);
      end
      else if (!tag_done_i && done_seen)
      begin
        report_mismatch("tag_done_o fell after it had risen");
      end

      // Scoreboard, a transfer counts at the edge that follows this sample
      if (up_v_i && up_ready_i)
      begin
        expect_q.push_back(up_data_i);
      end
      if (down_v_i && down_ready_i)
      begin
        delivered++;
        if (expect_q.size() == 0)
        begin
          report_mismatch($sformatf("down_data_o %h with no word outstanding", down_data_i));
        end
        else
        begin
          oldest = expect_q.pop_front();
          if (down_data_i !== oldest)
          begin
            report_mismatch($sformatf("down_data_o is %h, expected %h", down_data_i, oldest));
          end
        end
      end
    end

    // Closing checks once the stimulus is over
    if (end_i && !finished)
    begin
      if (delivered != words_i)
      begin
        report_mismatch($sformatf("%0d words delivered, expected %0d", delivered, words_i));
      end
      if (expect_q.size() != 0)
      begin
        report_mismatch($sformatf("%0d accepted words never delivered", expect_q.size()));
      end
      if (down_v_i)
      begin
        report_mismatch("down_v_o still high at the end");
      end
      if (!done_seen)
      begin
        report_mismatch("tag_done_o never rose");
      end
      finished = 1'b1;
    end
  end

endmodule

// ==== tests/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk
);

  // Free-running clock, 100 ns period, starting low
  initial
  begin
    clk = 1'b0;
    forever
    begin
      // Half period in ns
      #50 clk = ~clk;
    end
  end

endmodule

// ==== tests/tb_top.sv ====
`timescale 1ns/1ps

module tb_top;

  localparam int word_total = 300;
  localparam int rom_depth  = 2**tag_pkg::trace_addr_width;

  logic                                  clk;
  logic                                  rst_i;
  logic [tag_pkg::trace_word_width-1:0]  rom [rom_depth];
  logic [tag_pkg::trace_addr_width-1:0]  rom_addr;
  logic [tag_pkg::trace_word_width-1:0]  rom_data;
  logic                                  tag_done;
  logic [tag_pkg::tag_payload_width-1:0] cfg1;
  logic [tag_pkg::tag_payload_width-1:0] cfg2;
  logic [tag_pkg::tag_payload_width-1:0] cfg3;
  logic                                  up_v_i;
  logic [link_pkg::link_data_width-1:0]  up_data_i;
  logic                                  up_ready;
  logic                                  link_v;
  logic [link_pkg::link_data_width-1:0]  link_data;
  logic                                  link_token;
  logic                                  down_v;
  logic [link_pkg::link_data_width-1:0]  down_data;
  logic                                  down_ready_i;
  logic                                  rom_ready   = 1'b0;
  logic                                  end_check   = 1'b0;
  int                                    trace_cycles = 0;
  int                                    errors;
  int                                    delivered;
  logic                                  finished;

  tb_clock_gen clock_gen (
    .clk (clk)
  );

  // The ROM answers in the same cycle
  assign rom_data = rom[rom_addr];

  // Link output wraps straight back into the link input, tokens included
  chip_top UUT (
    .clk          (clk),
    .rst_i        (rst_i),
    .rom_addr_o   (rom_addr),
    .rom_data_i   (rom_data),
    .tag_done_o   (tag_done),
    .cfg1_o       (cfg1),
    .cfg2_o       (cfg2),
    .cfg3_o       (cfg3),
    .up_v_i       (up_v_i),
    .up_data_i    (up_data_i),
    .up_ready_o   (up_ready),
    .link_v_o     (link_v),
    .link_data_o  (link_data),
    .link_token_i (link_token),
    .link_v_i     (link_v),
    .link_data_i  (link_data),
    .link_token_o (link_token),
    .down_v_o     (down_v),
    .down_data_o  (down_data),
    .down_ready_i (down_ready_i)
  );

  tb_checker checks (
    .clk          (clk),
    .rst_i        (rst_i),
    .rom_i        (rom),
    .rom_addr_i   (rom_addr),
    .words_i      (word_total),
    .up_v_i       (up_v_i),
    .up_data_i    (up_data_i),
    .up_ready_i   (up_ready),
    .link_v_i     (link_v),
    .link_token_i (link_token),
    .tag_done_i   (tag_done),
    .cfg1_i       (cfg1),
    .cfg2_i       (cfg2),
    .cfg3_i       (cfg3),
    .down_v_i     (down_v),
    .down_data_i  (down_data),
    .down_ready_i (down_ready_i),
    .end_i        (end_check),
    .errors_o     (errors),
    .delivered_o  (delivered),
    .finished_o   (finished)
  );

  //////////////////////////////////////////////////
  // Trace ROM contents
  //////////////////////////////////////////////////

  task automatic build_rom();
    tag_pkg::trace_word_u w;
    // Unused words hold finish commands tagged with their own address
    for (int a = 0; a < rom_depth; a++)
    begin
      rom[a] = {2'(tag_pkg::op_finish), tag_pkg::trace_count_width'(a)};
    end
    // Client 0 bit 0 goes up first so the link opens early
    w                          = '0;
    w.send_view.op             = tag_pkg::op_send;
    w.send_view.data_not_reset = 1'b1;
    w.send_view.len            = 3'd1;
    w.send_view.payload        = 7'h01;
    rom[0]                     = w;
    trace_cycles               = 9;
    // Random commands only ever touch clients 1 to 3
    for (int a = 1; a <= 20; a++)
    begin
      w = '0;
      if (($urandom % 3) == 0)
      begin
        w.wait_view.op    = tag_pkg::op_wait;
        w.wait_view.count = tag_pkg::trace_count_width'($urandom % 8);
        trace_cycles      = trace_cycles + 1 + int'(w.wait_view.count);
      end
      else
      begin
        w.send_view.op             = tag_pkg::op_send;
        w.send_view.id             = 2'(1 + ($urandom % 3));
        w.send_view.data_not_reset = ($urandom % 4) != 0;
        w.send_view.len            = 3'($urandom);
        w.send_view.payload        = 7'($urandom);
        trace_cycles               = trace_cycles + 8 + int'(w.send_view.len);
      end
      rom[a] = w;
    end
    w              = '0;
    w.wait_view.op = tag_pkg::op_finish;
    rom[21]        = w;
    trace_cycles   = trace_cycles + 1;
  endtask

  // Offers random words and holds each one until the DUT takes it
  task automatic send_words(input int total);
    int   sent;
    logic taken;
    sent = 0;
    while (sent < total)
    begin
      if (!up_v_i && ($urandom % 4) != 0)
      begin
        up_v_i    = 1'b1;
        up_data_i = link_pkg::link_data_width'($urandom);
      end
      @(negedge clk);
      taken = up_v_i && up_ready;
      @(posedge clk);
      #1;
      if (taken)
      begin
        sent++;
        up_v_i = 1'b0;
      end
    end
    up_v_i = 1'b0;
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial
  begin : main
    rst_i        = 1'b1;
    up_v_i       = 1'b0;
    // The seeding draw also gives the idle data word
    up_data_i    = link_pkg::link_data_width'($urandom(32'hac94_d5b1));
    down_ready_i = 1'b0;
    build_rom();
    rom_ready = 1'b1;
    repeat (16) @(posedge clk);
    #1;
    rst_i = 1'b0;
    send_words(word_total);
    // Let the FIFO drain under the random down_ready_i
    while (delivered < word_total)
    begin
      @(posedge clk);
    end
    repeat (2) @(posedge clk);
    #1;
    end_check = 1'b1;
    wait (finished);
    $display("tb_top: %0d errors, %0d of %0d words delivered", errors, delivered, word_total);
    if (errors == 0)
    begin
      $display("*** PASSED ***");
    end
    else
    begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // Sink accepts about 60 percent of the cycles
  initial
  begin : ready_driver
    wait (rom_ready);
    forever
    begin
      @(posedge clk);
      #1;
      down_ready_i = ($urandom % 10) < 6;
    end
  end

  // Budget is reset, the whole trace, and four cycles per word
  initial
  begin : watchdog
    int limit;
    wait (rom_ready);
    limit = 16 + trace_cycles + word_total * 4;
    repeat (limit) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", limit);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

// ==== vlog.f ====
hw/tag_pkg.sv
hw/link_pkg.sv
hw/tag_trace_replay.sv
hw/tag_master.sv
hw/tag_client.sv
hw/link_tx.sv
hw/link_rx.sv
hw/chip_top.sv
tests/tb_clock_gen.sv
tests/link_credit_assert.sv
tests/tb_checker.sv
tests/tb_top.sv
